//--- verilog/tag_store_defines.svh
// Tag store geometry
// Way count, set index width, tag width and tag RAM read latency
// shared by the packages, the interface and the RTL

`ifndef TAG_STORE_DEFINES_SVH
`define TAG_STORE_DEFINES_SVH

// Number of ways per set
`define TAG_WAYS 4

// Set index width, 16 sets
`define TAG_INDEX_W 4

// Width of a stored tag
`define TAG_TAG_W 8

// Cycles from RAM read request to valid read data
`define TAG_RAM_LATENCY 1

`endif

//--- verilog/tag_store_pkg.sv
// Tag store storage types
// Tag, index and way encodings, the stored tag entry and the
// per-set pseudo-LRU tree state

`default_nettype none

`include "tag_store_defines.svh"

package tag_store_pkg;

  // Tag as stored in the RAM and as carried by a request
  typedef logic [`TAG_TAG_W-1:0] tag_t;

  // Set index, doubles as the RAM address
  typedef logic [`TAG_INDEX_W-1:0] index_t;

  // One bit per way
  typedef logic [`TAG_WAYS-1:0] way_mask_t;

  // Binary way number
  typedef logic [$clog2(`TAG_WAYS)-1:0] way_bin_t;

  // One RAM word
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Tree bits of one set, bit 0 is the root
  typedef logic [`TAG_WAYS-2:0] plru_tree_t;

endpackage

`default_nettype wire

//--- verilog/tag_req_pkg.sv
// Tag store request and response types
// Operation modes and the packed request and response payloads
// exchanged over the valid/ready handshakes

`default_nettype none

package tag_req_pkg;

  // Operation requested from the tag store
  typedef enum logic [1:0] {
    LOOKUP = 2'd0,
    FLUSH  = 2'd1
  } tag_mode_e;

  // Request payload
  typedef struct packed {
    tag_mode_e                 mode;
    tag_store_pkg::index_t     index;
    tag_store_pkg::tag_t       tag;
    logic                      dirty;     // Lookup comes from a write
    tag_store_pkg::way_mask_t  way_mask;  // Ways the operation may touch
  } tag_req_t;

  // Response payload
  typedef struct packed {
    logic                      hit;
    tag_store_pkg::way_mask_t  way;       // One-hot selected way
    logic                      evict;     // Selected line held dirty data
    tag_store_pkg::tag_t       evict_tag;
  } tag_res_t;

endpackage

`default_nettype wire

//--- verilog/tag_ram_if.sv
// Tag RAM access interface
// Carries read and write requests from the controller to the
// per-way tag RAMs and returns read data and tag compare results

`default_nettype none

`include "tag_store_defines.svh"

interface tag_ram_if;

  // Controller side
  tag_store_pkg::way_mask_t   req;      // Access per way
  tag_store_pkg::way_mask_t   we;       // Write when set together with req
  tag_store_pkg::index_t      index;
  tag_store_pkg::tag_entry_t  wdata;
  tag_store_pkg::tag_t        cmp_tag;  // Tag to compare read data against

  // Bank side
  logic                                        rvalid;  // Single pulse per read
  tag_store_pkg::tag_entry_t [`TAG_WAYS-1:0]  rdata;
  tag_store_pkg::way_mask_t                    match;

  modport ctrl (output req, we, index, wdata, cmp_tag, input rvalid, rdata, match);

  modport bank (input req, we, index, wdata, cmp_tag, output rvalid, rdata, match);

endinterface

`default_nettype wire

//--- verilog/tag_ram_bank.sv
// Tag RAM bank
// One tag array per way with registered read data, a read-valid
// delay line matching the RAM latency and a per-way tag compare

`default_nettype none

`include "tag_store_defines.svh"

module tag_ram_bank (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  tag_ram_if.bank    ram
);

  localparam int unsigned Sets = 1 << `TAG_INDEX_W;
  localparam int unsigned Lat  = `TAG_RAM_LATENCY;

  logic           rd_any;
  logic [Lat-1:0] rd_pipe_q;

  // Any way reading this cycle
  assign rd_any = |(ram.req & ~ram.we);

  // Read token travels with the data
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_pipe_q <= '0;
    end else begin
      rd_pipe_q[0] <= rd_any;
      for (int i = 1; i < Lat; i++) begin
        rd_pipe_q[i] <= rd_pipe_q[i-1];
      end
    end
  end

  assign ram.rvalid = rd_pipe_q[Lat-1];

  for (genvar w = 0; w < `TAG_WAYS; w++) begin : gen_way
    tag_store_pkg::tag_entry_t mem_q [Sets];
    tag_store_pkg::tag_entry_t rd_q  [Lat];

    // Storage array, all lines invalid out of reset
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        for (int s = 0; s < Sets; s++) begin
          mem_q[s] <= '0;
        end
      end else if (ram.req[w] && ram.we[w]) begin
        mem_q[ram.index] <= ram.wdata;
      end
    end

    // Read register holds until the next read of this way
    always_ff @(posedge clk_i) begin
      if (ram.req[w] && !ram.we[w]) begin
        rd_q[0] <= mem_q[ram.index];
      end
      // Extra latency stages
      for (int i = 1; i < Lat; i++) begin
        rd_q[i] <= rd_q[i-1];
      end
    end

    assign ram.rdata[w] = rd_q[Lat-1];

    // Tag only, valid and dirty are judged by the controller
    assign ram.match[w] = (rd_q[Lat-1].tag == ram.cmp_tag);
  end

endmodule

`default_nettype wire

//--- verilog/plru_victim_sel.sv
// Tree pseudo-LRU victim selection
// Keeps one tree per set, picks the victim way among the masked
// ways and moves the tree away from each way that was used

`default_nettype none

`include "tag_store_defines.svh"

module plru_victim_sel (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire tag_store_pkg::index_t     index_i,
  input  wire tag_store_pkg::way_mask_t  way_mask_i,
  input  wire tag_store_pkg::way_mask_t  way_valid_i,
  input  wire logic                      update_i,
  input  wire tag_store_pkg::way_mask_t  update_way_i,
  output tag_store_pkg::way_mask_t       victim_o
);

  localparam int unsigned Sets = 1 << `TAG_INDEX_W;

  tag_store_pkg::plru_tree_t tree_q [Sets];
  tag_store_pkg::plru_tree_t cur_tree;
  tag_store_pkg::plru_tree_t new_tree;
  tag_store_pkg::way_mask_t  free_ways;
  tag_store_pkg::way_mask_t  free_low;
  tag_store_pkg::way_mask_t  mask_low;
  tag_store_pkg::way_mask_t  tree_way;
  tag_store_pkg::way_bin_t   tree_bin;
  tag_store_pkg::way_bin_t   upd_bin;

  assign cur_tree = tree_q[index_i];

  // Walk the tree, a zero bit points to the lower half
  always_comb begin
    tree_bin[1] = cur_tree[0];
    tree_bin[0] = tree_bin[1] ? cur_tree[2] : cur_tree[1];
  end

  assign tree_way = tag_store_pkg::way_mask_t'(1) << tree_bin;

  // Masked ways holding no line
  assign free_ways = way_mask_i & ~way_valid_i;

  // Isolate the lowest set bit
  assign free_low = free_ways & (~free_ways + tag_store_pkg::way_mask_t'(1));
  assign mask_low = way_mask_i & (~way_mask_i + tag_store_pkg::way_mask_t'(1));

  always_comb begin
    if (|free_ways) begin
      victim_o = free_low;
    end else if (|(tree_way & way_mask_i)) begin
      victim_o = tree_way;
    end else begin
      // Tree points outside the mask
      victim_o = mask_low;
    end
  end

  // Way used by the completed lookup
  always_comb begin
    upd_bin = '0;
    for (int w = 0; w < `TAG_WAYS; w++) begin
      if (update_way_i[w]) begin
        upd_bin = tag_store_pkg::way_bin_t'(w);
      end
    end
  end

  // Path bits point away from the used way
  always_comb begin
    new_tree    = cur_tree;
    new_tree[0] = ~upd_bin[1];
    if (upd_bin[1]) begin
      new_tree[2] = ~upd_bin[0];
    end else begin
      new_tree[1] = ~upd_bin[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < Sets; s++) begin
        tree_q[s] <= '0;
      end
    end else if (update_i) begin
      tree_q[index_i] <= new_tree;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tag_store_ctrl.sv
// Tag store controller
// Accepts one request at a time, reads the masked ways, builds the
// hit, miss or flush response and writes the updated entry back

`default_nettype none

`include "tag_store_defines.svh"

module tag_store_ctrl (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire logic                      req_valid_i,
  output logic                           req_ready_o,
  input  wire tag_req_pkg::tag_req_t     req_i,
  output logic                           res_valid_o,
  input  wire logic                      res_ready_i,
  output tag_req_pkg::tag_res_t          res_o,
  tag_ram_if.ctrl                        ram,
  input  wire tag_store_pkg::way_mask_t  victim_i,
  output logic                           plru_update_o,
  output tag_store_pkg::way_mask_t       plru_way_o,
  output tag_store_pkg::index_t          plru_index_o,
  output tag_store_pkg::way_mask_t       way_valid_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_RESP,
    ST_WRITE
  } state_e;

  state_e                     state_q;
  state_e                     state_d;
  tag_req_pkg::tag_req_t      req_q;
  logic                       rd_done_q;
  logic                       res_fire;
  logic                       is_flush;
  logic                       is_hit;
  logic                       need_wr;
  tag_store_pkg::way_mask_t   hit_vec;
  tag_store_pkg::way_mask_t   hit_way;
  tag_store_pkg::way_mask_t   sel_way;
  tag_store_pkg::way_bin_t    sel_bin;
  tag_store_pkg::tag_entry_t  sel_entry;
  tag_store_pkg::way_mask_t   wr_way_d;
  tag_store_pkg::way_mask_t   wr_way_q;
  tag_store_pkg::tag_entry_t  wr_entry_d;
  tag_store_pkg::tag_entry_t  wr_entry_q;

  assign is_flush = (req_q.mode == tag_req_pkg::FLUSH);

  // Valid bits of the read set, also feed the PLRU
  always_comb begin
    for (int w = 0; w < `TAG_WAYS; w++) begin
      way_valid_o[w] = ram.rdata[w].valid;
    end
  end

  // Hit needs a valid masked way with equal tag
  assign hit_vec = ram.match & req_q.way_mask & way_valid_o;
  assign hit_way = hit_vec & (~hit_vec + tag_store_pkg::way_mask_t'(1));
  assign is_hit  = !is_flush && (|hit_vec);

  // Way the response and write-back refer to
  always_comb begin
    if (is_flush) begin
      sel_way = req_q.way_mask;
    end else if (is_hit) begin
      sel_way = hit_way;
    end else begin
      sel_way = victim_i;
    end
  end

  always_comb begin
    sel_bin = '0;
    for (int w = 0; w < `TAG_WAYS; w++) begin
      if (sel_way[w]) begin
        sel_bin = tag_store_pkg::way_bin_t'(w);
      end
    end
  end

  assign sel_entry = ram.rdata[sel_bin];

  // Response straight from the read data, stable while held
  always_comb begin
    res_o     = '0;
    res_o.way = sel_way;
    if (is_hit) begin
      res_o.hit = 1'b1;
    end else begin
      // Miss or flush reports the line that goes away
      res_o.evict     = sel_entry.valid & sel_entry.dirty;
      res_o.evict_tag = sel_entry.tag;
    end
  end

  // Entry to write once the response is taken
  always_comb begin
    wr_way_d   = sel_way;
    wr_entry_d = '0;
    need_wr    = 1'b0;
    if (is_flush) begin
      need_wr = 1'b1;
    end else if (!is_hit) begin
      // Refill the victim
      need_wr          = 1'b1;
      wr_entry_d.valid = 1'b1;
      wr_entry_d.dirty = req_q.dirty;
      wr_entry_d.tag   = req_q.tag;
    end else if (req_q.dirty && !sel_entry.dirty) begin
      // Clean line becomes dirty
      need_wr          = 1'b1;
      wr_entry_d.valid = 1'b1;
      wr_entry_d.dirty = 1'b1;
      wr_entry_d.tag   = req_q.tag;
    end
  end

  assign req_ready_o = (state_q == ST_IDLE);
  assign res_valid_o = (state_q == ST_RESP) && (ram.rvalid || rd_done_q);
  assign res_fire    = res_valid_o && res_ready_i;

  // Only lookups age the tree
  assign plru_update_o = res_fire && !is_flush;
  assign plru_way_o    = sel_way;
  assign plru_index_o  = req_q.index;

  // RAM port
  always_comb begin
    ram.req     = '0;
    ram.we      = '0;
    ram.index   = req_q.index;
    ram.wdata   = wr_entry_q;
    ram.cmp_tag = req_q.tag;
    case (state_q)
      ST_READ: ram.req = req_q.way_mask;
      ST_WRITE: begin
        ram.req = wr_way_q;
        ram.we  = wr_way_q;
      end
      default: ram.req = '0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (req_valid_i) state_d = ST_READ;
      ST_READ: state_d = ST_RESP;
      ST_RESP: if (res_fire) state_d = need_wr ? ST_WRITE : ST_IDLE;
      ST_WRITE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      rd_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Remember the read pulse until the response leaves
      if (res_fire) begin
        rd_done_q <= 1'b0;
      end else if (ram.rvalid) begin
        rd_done_q <= 1'b1;
      end
    end
  end

  // Request and write-back payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
    if (res_fire) begin
      wr_way_q   <= wr_way_d;
      wr_entry_q <= wr_entry_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tag_store_top.sv
// Set-associative tag store
// Packs the request ports into a request struct, unpacks the
// response and ties the controller, tag RAMs and PLRU together

`default_nettype none

module tag_store_top (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire logic                      req_valid_i,
  output logic                           req_ready_o,
  input  wire tag_req_pkg::tag_mode_e    req_mode_i,
  input  wire tag_store_pkg::index_t     req_index_i,
  input  wire tag_store_pkg::tag_t       req_tag_i,
  input  wire logic                      req_dirty_i,
  input  wire tag_store_pkg::way_mask_t  req_way_mask_i,
  output logic                           res_valid_o,
  input  wire logic                      res_ready_i,
  output logic                           res_hit_o,
  output tag_store_pkg::way_mask_t       res_way_o,
  output logic                           res_evict_o,
  output tag_store_pkg::tag_t            res_evict_tag_o
);

  tag_req_pkg::tag_req_t     req;
  tag_req_pkg::tag_res_t     res;
  tag_store_pkg::way_mask_t  victim;
  logic                      plru_update;
  tag_store_pkg::way_mask_t  plru_way;
  tag_store_pkg::index_t     plru_index;
  tag_store_pkg::way_mask_t  way_valid;
  tag_store_pkg::way_mask_t  req_mask_q;

  tag_ram_if ram_if ();

  // Request fields
  assign req.mode     = req_mode_i;
  assign req.index    = req_index_i;
  assign req.tag      = req_tag_i;
  assign req.dirty    = req_dirty_i;
  assign req.way_mask = req_way_mask_i;

  // Response fields
  assign res_hit_o       = res.hit;
  assign res_way_o       = res.way;
  assign res_evict_o     = res.evict;
  assign res_evict_tag_o = res.evict_tag;

  // Way mask of the accepted request, held for the victim choice
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_mask_q <= req.way_mask;
    end
  end

  tag_store_ctrl tag_store_ctrl_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_i         (req),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_o         (res),
    .ram           (ram_if.ctrl),
    .victim_i      (victim),
    .plru_update_o (plru_update),
    .plru_way_o    (plru_way),
    .plru_index_o  (plru_index),
    .way_valid_o   (way_valid)
  );

  tag_ram_bank tag_ram_bank_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ram     (ram_if.bank)
  );

  // Victim is looked up for the request held by the controller
  plru_victim_sel plru_victim_sel_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .index_i      (plru_index),
    .way_mask_i   (req_mask_q),
    .way_valid_i  (way_valid),
    .update_i     (plru_update),
    .update_way_i (plru_way),
    .victim_o     (victim)
  );

endmodule

`default_nettype wire

//--- verification/tag_store_tb.sv
// Tag store testbench
// Replays lookups and flushes from a stimulus file, throttles the
// response with random back-pressure and checks every response,
// its latency and that it is held while not accepted

`default_nettype none

`include "tag_store_defines.svh"

module tag_store_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned WaitLimit = 100;
  localparam int unsigned RespLat   = 1 + `TAG_RAM_LATENCY;

  logic                      clk_i;
  logic                      reset_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  tag_req_pkg::tag_mode_e    req_mode_i;
  tag_store_pkg::index_t     req_index_i;
  tag_store_pkg::tag_t       req_tag_i;
  logic                      req_dirty_i;
  tag_store_pkg::way_mask_t  req_way_mask_i;
  logic                      res_valid_o;
  logic                      res_ready_i;
  logic                      res_hit_o;
  tag_store_pkg::way_mask_t  res_way_o;
  logic                      res_evict_o;
  tag_store_pkg::tag_t       res_evict_tag_o;

  int     mismatches;
  int     timeouts;
  int     other_errors;
  int     requests;
  integer seed;
  logic   abort;

  tag_store_top tag_store_top_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_mode_i      (req_mode_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_mask_i  (req_way_mask_i),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_hit_o       (res_hit_o),
    .res_way_o       (res_way_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // Idle handshake state expected in and right after reset
  task automatic check_idle_state(input string phase);
    if (res_valid_o !== 1'b0) begin
      $display("MISMATCH at %0t ns: res_valid_o is %b %s", $time, res_valid_o, phase);
      mismatches++;
    end
    if (req_ready_o !== 1'b1) begin
      $display("MISMATCH at %0t ns: req_ready_o is %b %s", $time, req_ready_o, phase);
      mismatches++;
    end
  endtask

  // Hold reset for 16 cycles, checking outputs on each falling edge
  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (16) begin
      @(negedge clk_i);
      check_idle_state("during reset");
    end
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle_state("after reset");
  endtask

  // One request from handshake to accepted response
  task automatic run_request(input int line_no, input logic [7:0] mode_v,
                             input logic [7:0] index_v, input logic [7:0] tag_v,
                             input logic [7:0] dirty_v, input logic [7:0] mask_v,
                             input logic [7:0] hit_e, input logic [7:0] way_e,
                             input logic [7:0] evict_e, input logic [7:0] etag_e);
    int                        cycles;
    logic                      accepted;
    logic [31:0]               rnd;
    logic                      hit_q;
    tag_store_pkg::way_mask_t  way_q;
    logic                      evict_q;
    tag_store_pkg::tag_t       etag_q;
    cycles = 0;
    while (!req_ready_o && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!req_ready_o) begin
      $display("Timeout at %0t ns: DUT never got ready for stimulus line %0d", $time, line_no);
      timeouts++;
      abort = 1'b1;
    end else begin
      req_valid_i    = 1'b1;
      req_mode_i     = tag_req_pkg::tag_mode_e'(mode_v[1:0]);
      req_index_i    = index_v[`TAG_INDEX_W-1:0];
      req_tag_i      = tag_v[`TAG_TAG_W-1:0];
      req_dirty_i    = dirty_v[0];
      req_way_mask_i = mask_v[`TAG_WAYS-1:0];
      requests++;
      // Handshake happens on the rising edge just passed
      @(negedge clk_i);
      req_valid_i = 1'b0;
      // Request fields may change once accepted
      req_index_i    = ~req_index_i;
      req_tag_i      = ~req_tag_i;
      req_dirty_i    = ~req_dirty_i;
      req_way_mask_i = ~req_way_mask_i;
      cycles = 1;
      while (!res_valid_o && cycles < WaitLimit) begin
        @(negedge clk_i);
        cycles++;
      end
      if (!res_valid_o) begin
        $display("Timeout at %0t ns: no response for stimulus line %0d", $time, line_no);
        timeouts++;
        abort = 1'b1;
      end else begin
        if (cycles != RespLat) begin
          $display("MISMATCH at %0t ns: line %0d response after %0d cycles, expected %0d",
                   $time, line_no, cycles, RespLat);
          mismatches++;
        end
        if (res_hit_o !== hit_e[0]) begin
          $display("MISMATCH at %0t ns: line %0d hit %b, expected %b",
                   $time, line_no, res_hit_o, hit_e[0]);
          mismatches++;
        end
        if (res_way_o !== way_e[`TAG_WAYS-1:0]) begin
          $display("MISMATCH at %0t ns: line %0d way %h, expected %h",
                   $time, line_no, res_way_o, way_e[`TAG_WAYS-1:0]);
          mismatches++;
        end
        if (res_evict_o !== evict_e[0]) begin
          $display("MISMATCH at %0t ns: line %0d evict %b, expected %b",
                   $time, line_no, res_evict_o, evict_e[0]);
          mismatches++;
        end
        if (res_evict_tag_o !== etag_e[`TAG_TAG_W-1:0]) begin
          $display("MISMATCH at %0t ns: line %0d evict tag %h, expected %h",
                   $time, line_no, res_evict_tag_o, etag_e[`TAG_TAG_W-1:0]);
          mismatches++;
        end
        hit_q    = res_hit_o;
        way_q    = res_way_o;
        evict_q  = res_evict_o;
        etag_q   = res_evict_tag_o;
        accepted = 1'b0;
        cycles   = 0;
        // Random ready, response must hold until taken
        while (!accepted && cycles < WaitLimit) begin
          rnd = $random(seed);
          res_ready_i = rnd[0];
          @(negedge clk_i);
          cycles++;
          if (res_ready_i) begin
            accepted = 1'b1;
          end else begin
            if (res_valid_o !== 1'b1 || req_ready_o !== 1'b0) begin
              $display("MISMATCH at %0t ns: line %0d valid %b ready %b while stalled",
                       $time, line_no, res_valid_o, req_ready_o);
              mismatches++;
            end
            if ({res_hit_o, res_way_o, res_evict_o, res_evict_tag_o} !==
                {hit_q, way_q, evict_q, etag_q}) begin
              $display("MISMATCH at %0t ns: line %0d response changed while stalled",
                       $time, line_no);
              mismatches++;
            end
          end
        end
        res_ready_i = 1'b0;
        if (!accepted) begin
          $display("Timeout at %0t ns: response of line %0d never taken", $time, line_no);
          timeouts++;
          abort = 1'b1;
        end
      end
    end
  endtask

  initial begin
    int         fd;
    int         n;
    int         line_no;
    string      line;
    logic [7:0] mode_v;
    logic [7:0] index_v;
    logic [7:0] tag_v;
    logic [7:0] dirty_v;
    logic [7:0] mask_v;
    logic [7:0] hit_e;
    logic [7:0] way_e;
    logic [7:0] evict_e;
    logic [7:0] etag_e;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    req_valid_i    = 1'b0;
    req_mode_i     = tag_req_pkg::LOOKUP;
    req_index_i    = '0;
    req_tag_i      = '0;
    req_dirty_i    = 1'b0;
    req_way_mask_i = '0;
    res_ready_i    = 1'b0;
    mismatches     = 0;
    timeouts       = 0;
    other_errors   = 0;
    requests       = 0;
    abort          = 1'b0;
    seed           = 32'hdf954511;
    apply_reset();
    fd = $fopen("verification/tag_store_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verification/tag_store_stim.txt");
      other_errors++;
    end else begin
      line_no = 0;
      while (!abort && !$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        // Skip comments and blank lines
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", mode_v, index_v, tag_v,
                      dirty_v, mask_v, hit_e, way_e, evict_e, etag_e);
          if (n != 9) begin
            $display("Stimulus line %0d could not be read, found %0d fields", line_no, n);
            other_errors++;
          end else begin
            run_request(line_no, mode_v, index_v, tag_v, dirty_v, mask_v,
                        hit_e, way_e, evict_e, etag_e);
          end
        end
      end
      $fclose(fd);
    end
    if (requests == 0) begin
      $display("No request was run from the stimulus file");
      other_errors++;
    end
    $display("Requests: %0d, mismatches: %0d, timeouts: %0d, other errors: %0d",
             requests, mismatches, timeouts, other_errors);
    if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tag_store_stim.txt
# mode(0 lookup, 1 flush) index tag dirty way_mask, all hex
# then expected hit way(one-hot) evict evict_tag, all hex
0 3 a1 0 f 0 1 0 00
0 3 b2 1 f 0 2 0 00
0 3 c3 0 f 0 4 0 00
0 3 d4 1 f 0 8 0 00
0 3 a1 0 f 1 1 0 00
0 3 c3 1 f 1 4 0 00
0 3 b2 0 f 1 2 0 00
0 3 e5 0 f 0 8 1 d4
0 3 f6 1 f 0 1 0 a1
0 3 17 0 f 0 4 1 c3
0 3 28 0 f 0 2 1 b2
0 3 f6 0 f 1 1 0 00
0 3 f6 0 e 0 8 0 e5
0 3 f6 0 f 1 1 0 00
0 3 28 0 3 1 2 0 00
0 3 39 1 3 0 1 1 f6
0 3 17 0 3 0 1 1 39
0 3 4a 0 c 0 4 0 17
0 5 5b 1 6 0 2 0 00
0 5 5b 0 9 0 1 0 00
0 5 5b 0 f 1 1 0 00
1 5 00 0 2 0 2 1 5b
1 3 00 0 4 0 4 0 4a
0 3 4a 1 f 0 4 0 00
1 3 00 0 4 0 4 1 4a
0 5 5b 0 2 0 2 0 00
1 9 00 0 8 0 8 0 00
0 3 4a 0 f 0 4 0 00
0 3 4a 1 f 1 4 0 00
0 3 f6 0 f 1 8 0 00
0 3 6c 0 f 0 2 0 28
0 3 7d 0 f 0 4 1 4a

//--- filelist.f
+incdir+verilog
verilog/tag_store_pkg.sv
verilog/tag_req_pkg.sv
verilog/tag_ram_if.sv
verilog/tag_ram_bank.sv
verilog/plru_victim_sel.sv
verilog/tag_store_ctrl.sv
verilog/tag_store_top.sv
verification/tag_store_tb.sv

//--- Bender.yml
package:
  name: tag_store

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tag_store_pkg.sv
      - verilog/tag_req_pkg.sv
      - verilog/tag_ram_if.sv
      - verilog/tag_ram_bank.sv
      - verilog/plru_victim_sel.sv
      - verilog/tag_store_ctrl.sv
      - verilog/tag_store_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/tag_store_tb.sv
